//--- hdl/udp_tx_macros.svh
`ifndef UDP_TX_MACROS_SVH
`define UDP_TX_MACROS_SVH

// Stream and frame geometry
`define WORD_W         16
`define PAYLOAD_BITS   256
`define PAYLOAD_WORDS  16
`define HDR_WORDS      25   // Preamble/SFD, Ethernet, IPv4 and UDP
`define FCS_WORDS      2
`define GAP_CYCLES     6    // 12 bytes of idle
`define QUEUE_DEPTH    4

// Fixed lengths for a 32 byte payload
`define IP_TOTAL_LEN   16'd60
`define UDP_LEN        16'd40

// Header field values after reset
`define RESET_DST_MAC  48'h0000_0000_0001
`define RESET_SRC_MAC  48'h0000_0000_0000
`define RESET_DST_IP   32'h0000_0001
`define RESET_SRC_IP   32'h0000_0000
`define RESET_DST_PORT 16'h0001
`define RESET_SRC_PORT 16'h0000
`define RESET_TTL      8'd64

`endif

//--- hdl/udp_tx_pkg.sv
package udp_tx_pkg;

	// Framer sequencing
	typedef enum logic [2:0]
	{
		IDLE,
		SEND_HDR,
		SEND_DATA,
		SEND_FCS,
		SEND_GAP
	} tx_state_e;

	// Configuration register map
	typedef enum logic [3:0]
	{
		REG_DST_MAC_HI = 4'd0,
		REG_DST_MAC_LO = 4'd1,
		REG_SRC_MAC_HI = 4'd2,
		REG_SRC_MAC_LO = 4'd3,
		REG_SRC_IP     = 4'd4,
		REG_DST_IP     = 4'd5,
		REG_PORTS      = 4'd6,   // Source port high, destination port low
		REG_ID_TTL     = 4'd7
	} cfg_reg_e;

endpackage

//--- hdl/hdr_cfg_if.sv
`timescale 1ns/100ps

interface hdr_cfg_if;

	logic [47:0] dst_mac;
	logic [47:0] src_mac;
	logic [31:0] src_ip;
	logic [31:0] dst_ip;
	logic [15:0] src_port;
	logic [15:0] dst_port;
	logic [15:0] ip_id;
	logic [7:0]  ttl;
	logic [15:0] ip_checksum;   // Registered with the fields

	modport cfg
	(
		output dst_mac, src_mac, src_ip, dst_ip, src_port, dst_port, ip_id, ttl, ip_checksum
	);

	modport framer
	(
		input dst_mac, src_mac, src_ip, dst_ip, src_port, dst_port, ip_id, ttl, ip_checksum
	);

endinterface

//--- hdl/udp_cfg_regs.sv
`timescale 1ns/100ps
`include "udp_tx_macros.svh"

module udp_cfg_regs
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cfg_wr,
	input  udp_tx_pkg::cfg_reg_e cfg_addr,
	input  logic [31:0]          cfg_wdata,
	hdr_cfg_if.cfg               hdr
);
	import udp_tx_pkg::*;

	logic [47:0] nxt_dst_mac, nxt_src_mac;
	logic [31:0] nxt_src_ip, nxt_dst_ip;
	logic [15:0] nxt_src_port, nxt_dst_port, nxt_ip_id;
	logic [7:0]  nxt_ttl;

	// One's-complement header sum, checksum word taken as zero
	function automatic logic [15:0] ip_cksum(input logic [31:0] sip, input logic [31:0] dip,
		input logic [15:0] id, input logic [7:0] t);
		logic [31:0] s;
		s = 32'h4500 + `IP_TOTAL_LEN + id + 32'h4000 + {t, 8'd17};
		s = s + sip[31:16] + sip[15:0] + dip[31:16] + dip[15:0];
		s = s[15:0] + s[31:16];   // Fold carries
		s = s[15:0] + s[31:16];   // Second fold catches the last carry
		return ~s[15:0];
	endfunction

	//////////////////////////////////////////////////
	// Write decode
	always_comb
	begin
		nxt_dst_mac  = hdr.dst_mac;
		nxt_src_mac  = hdr.src_mac;
		nxt_src_ip   = hdr.src_ip;
		nxt_dst_ip   = hdr.dst_ip;
		nxt_src_port = hdr.src_port;
		nxt_dst_port = hdr.dst_port;
		nxt_ip_id    = hdr.ip_id;
		nxt_ttl      = hdr.ttl;
		if (cfg_wr)
		begin
			case (cfg_addr)
				REG_DST_MAC_HI: nxt_dst_mac[47:32] = cfg_wdata[15:0];
				REG_DST_MAC_LO: nxt_dst_mac[31:0]  = cfg_wdata;
				REG_SRC_MAC_HI: nxt_src_mac[47:32] = cfg_wdata[15:0];
				REG_SRC_MAC_LO: nxt_src_mac[31:0]  = cfg_wdata;
				REG_SRC_IP:     nxt_src_ip         = cfg_wdata;
				REG_DST_IP:     nxt_dst_ip         = cfg_wdata;
				REG_PORTS:
				begin
					nxt_src_port = cfg_wdata[31:16];
					nxt_dst_port = cfg_wdata[15:0];
				end
				REG_ID_TTL:
				begin
					nxt_ip_id = cfg_wdata[31:16];
					nxt_ttl   = cfg_wdata[7:0];
				end
				default: ;   // Unmapped addresses ignored
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hdr.dst_mac     <= `RESET_DST_MAC;
			hdr.src_mac     <= `RESET_SRC_MAC;
			hdr.src_ip      <= `RESET_SRC_IP;
			hdr.dst_ip      <= `RESET_DST_IP;
			hdr.src_port    <= `RESET_SRC_PORT;
			hdr.dst_port    <= `RESET_DST_PORT;
			hdr.ip_id       <= 16'h0000;
			hdr.ttl         <= `RESET_TTL;
			hdr.ip_checksum <= ip_cksum(`RESET_SRC_IP, `RESET_DST_IP, 16'h0000, `RESET_TTL);
		end
		else
		begin
			hdr.dst_mac     <= nxt_dst_mac;
			hdr.src_mac     <= nxt_src_mac;
			hdr.src_ip      <= nxt_src_ip;
			hdr.dst_ip      <= nxt_dst_ip;
			hdr.src_port    <= nxt_src_port;
			hdr.dst_port    <= nxt_dst_port;
			hdr.ip_id       <= nxt_ip_id;
			hdr.ttl         <= nxt_ttl;
			hdr.ip_checksum <= ip_cksum(nxt_src_ip, nxt_dst_ip, nxt_ip_id, nxt_ttl);
		end
	end

endmodule

//--- hdl/payload_queue.sv
`timescale 1ns/100ps
`include "udp_tx_macros.svh"

module payload_queue
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [`PAYLOAD_BITS-1:0] wr_data,
	input  logic                     wr_en,
	input  logic                     pop,
	output logic [`PAYLOAD_BITS-1:0] head,
	output logic                     empty,
	output logic                     drop
);

	localparam int PTR_W = $clog2(`QUEUE_DEPTH);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(`QUEUE_DEPTH - 1);

	logic [`PAYLOAD_BITS-1:0] mem [`QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [PTR_W:0]   count;
	logic             full, do_wr, do_rd;

	assign full  = (count == (PTR_W+1)'(`QUEUE_DEPTH));
	assign empty = (count == '0);
	assign head  = mem[rd_ptr];   // Fall-through head
	assign do_wr = wr_en && !full;
	assign do_rd = pop && !empty;

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	//////////////////////////////////////////////////
	// Pointers and occupancy
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			drop   <= 1'b0;
		end
		else
		begin
			drop <= wr_en && full;   // Refused write
			if (do_wr)
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

//--- hdl/crc32_eth.sv
`timescale 1ns/100ps
`include "udp_tx_macros.svh"

module crc32_eth
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               crc_init,
	input  logic               crc_en,
	input  logic [`WORD_W-1:0] crc_data,
	output logic [31:0]        crc_value
);

	logic [31:0] crc;
	logic [31:0] fcs;

	// Reflected CRC-32, one byte, LSB first
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
		logic [31:0] r;
		r = c ^ {24'h0, b};
		for (int i = 0; i < 8; i++)
			r = r[0] ? ((r >> 1) ^ 32'hEDB8_8320) : (r >> 1);
		return r;
	endfunction

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			crc <= 32'hFFFF_FFFF;
		else if (crc_init)
			crc <= 32'hFFFF_FFFF;
		else if (crc_en)
			crc <= crc_byte(crc_byte(crc, crc_data[15:8]), crc_data[7:0]);   // High byte first
	end

	// Wire order: FCS byte 0 leads in bits 15..8 of the first word
	assign fcs       = ~crc;
	assign crc_value = {fcs[7:0], fcs[15:8], fcs[23:16], fcs[31:24]};

endmodule

//--- hdl/udp_frame_tx.sv
`timescale 1ns/100ps
`include "udp_tx_macros.svh"

module udp_frame_tx
(
	input  logic                     clk,
	input  logic                     rst_n,
	hdr_cfg_if.framer                hdr,
	input  logic [`PAYLOAD_BITS-1:0] head,
	input  logic                     empty,
	output logic                     pop,
	output logic                     crc_init,
	output logic                     crc_en,
	output logic [`WORD_W-1:0]       crc_data,
	input  logic [31:0]              crc_value,
	output logic [`WORD_W-1:0]       tx_data,
	output logic                     tx_valid,
	output logic                     tx_sof,
	output logic                     tx_eof
);
	import udp_tx_pkg::*;

	localparam logic [4:0] PRE_WORDS = 5'd4;   // Preamble and SFD, kept out of the CRC

	tx_state_e                state;
	logic [4:0]               cnt;
	logic [`PAYLOAD_BITS-1:0] payload;
	logic [`WORD_W-1:0]       hdr_word;
	logic [`WORD_W-1:0]       data_word;

	//////////////////////////////////////////////////
	// Header word select
	always_comb
	begin
		case (cnt)
			5'd0, 5'd1, 5'd2: hdr_word = 16'h5555;
			5'd3:  hdr_word = 16'h55D5;   // Last preamble byte, then SFD
			5'd4:  hdr_word = hdr.dst_mac[47:32];
			5'd5:  hdr_word = hdr.dst_mac[31:16];
			5'd6:  hdr_word = hdr.dst_mac[15:0];
			5'd7:  hdr_word = hdr.src_mac[47:32];
			5'd8:  hdr_word = hdr.src_mac[31:16];
			5'd9:  hdr_word = hdr.src_mac[15:0];
			5'd10: hdr_word = 16'h0800;   // IPv4 EtherType
			5'd11: hdr_word = 16'h4500;
			5'd12: hdr_word = `IP_TOTAL_LEN;
			5'd13: hdr_word = hdr.ip_id;
			5'd14: hdr_word = 16'h4000;   // DF set
			5'd15: hdr_word = {hdr.ttl, 8'd17};
			5'd16: hdr_word = hdr.ip_checksum;
			5'd17: hdr_word = hdr.src_ip[31:16];
			5'd18: hdr_word = hdr.src_ip[15:0];
			5'd19: hdr_word = hdr.dst_ip[31:16];
			5'd20: hdr_word = hdr.dst_ip[15:0];
			5'd21: hdr_word = hdr.src_port;
			5'd22: hdr_word = hdr.dst_port;
			5'd23: hdr_word = `UDP_LEN;
			default: hdr_word = 16'h0000;   // UDP checksum unused
		endcase
	end

	assign data_word = payload[`PAYLOAD_BITS-1 -: `WORD_W];

	// Queue pop and CRC feed track the word registered this edge
	assign pop      = (state == IDLE) && !empty;
	assign crc_init = pop;
	assign crc_en   = ((state == SEND_HDR) && (cnt >= PRE_WORDS)) || (state == SEND_DATA);
	assign crc_data = (state == SEND_DATA) ? data_word : hdr_word;

	always_ff @(posedge clk)
	begin
		if (pop)
			payload <= head;
		else if (state == SEND_DATA)
			payload <= payload << `WORD_W;
	end

	//////////////////////////////////////////////////
	// Frame sequencing
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state    <= IDLE;
			cnt      <= '0;
			tx_data  <= '0;
			tx_valid <= 1'b0;
			tx_sof   <= 1'b0;
			tx_eof   <= 1'b0;
		end
		else
		begin
			tx_sof <= 1'b0;
			tx_eof <= 1'b0;
			case (state)
				IDLE:
				begin
					tx_data  <= '0;
					tx_valid <= 1'b0;
					cnt      <= '0;
					if (!empty)
						state <= SEND_HDR;
				end
				SEND_HDR:
				begin
					tx_data  <= hdr_word;
					tx_valid <= 1'b1;
					tx_sof   <= (cnt == '0);
					cnt      <= (cnt == 5'(`HDR_WORDS - 1)) ? '0 : cnt + 1'b1;
					if (cnt == 5'(`HDR_WORDS - 1))
						state <= SEND_DATA;
				end
				SEND_DATA:
				begin
					tx_data <= data_word;
					cnt     <= (cnt == 5'(`PAYLOAD_WORDS - 1)) ? '0 : cnt + 1'b1;
					if (cnt == 5'(`PAYLOAD_WORDS - 1))
						state <= SEND_FCS;
				end
				SEND_FCS:
				begin
					tx_data <= (cnt == '0) ? crc_value[31:16] : crc_value[15:0];
					tx_eof  <= (cnt == 5'(`FCS_WORDS - 1));
					cnt     <= (cnt == 5'(`FCS_WORDS - 1)) ? '0 : cnt + 1'b1;
					if (cnt == 5'(`FCS_WORDS - 1))
						state <= SEND_GAP;
				end
				SEND_GAP:
				begin
					tx_data  <= '0;
					tx_valid <= 1'b0;   // Inter-packet gap
					cnt      <= cnt + 1'b1;
					if (cnt == 5'(`GAP_CYCLES - 1))
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- hdl/udp_tx_top.sv
`timescale 1ns/100ps
`include "udp_tx_macros.svh"

module udp_tx_top
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     cfg_wr,
	input  logic [3:0]               cfg_addr,
	input  logic [31:0]              cfg_wdata,
	input  logic [`PAYLOAD_BITS-1:0] send_package,
	input  logic                     send_valid,
	output logic                     drop,
	output logic [`WORD_W-1:0]       tx_data,
	output logic                     tx_valid,
	output logic                     tx_sof,
	output logic                     tx_eof
);
	import udp_tx_pkg::*;

	logic [`PAYLOAD_BITS-1:0] head;
	logic                     empty, pop;
	logic                     crc_init, crc_en;
	logic [`WORD_W-1:0]       crc_data;
	logic [31:0]              crc_value;

	hdr_cfg_if hdr_if ();

	udp_cfg_regs u_regs
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_wr    (cfg_wr),
		.cfg_addr  (cfg_reg_e'(cfg_addr)),
		.cfg_wdata (cfg_wdata),
		.hdr       (hdr_if.cfg)
	);

	payload_queue u_queue
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_data (send_package),
		.wr_en   (send_valid),
		.pop     (pop),
		.head    (head),
		.empty   (empty),
		.drop    (drop)
	);

	crc32_eth u_crc
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.crc_init  (crc_init),
		.crc_en    (crc_en),
		.crc_data  (crc_data),
		.crc_value (crc_value)
	);

	udp_frame_tx u_framer
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.hdr       (hdr_if.framer),
		.head      (head),
		.empty     (empty),
		.pop       (pop),
		.crc_init  (crc_init),
		.crc_en    (crc_en),
		.crc_data  (crc_data),
		.crc_value (crc_value),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.tx_sof    (tx_sof),
		.tx_eof    (tx_eof)
	);

endmodule

//--- tests/udp_tx_ref.svh
`ifndef UDP_TX_REF_SVH
`define UDP_TX_REF_SVH

// IPv4 header checksum, end-around carry folded after every word
function automatic logic [15:0] ref_ip_checksum(input logic [31:0] sip, input logic [31:0] dip,
	input logic [15:0] id, input logic [7:0] ttl);
	logic [15:0] w [9];
	logic [15:0] s;
	logic [16:0] t;
	w[0] = 16'h4500;
	w[1] = 16'd60;   // 20 + 8 + 32 bytes
	w[2] = id;
	w[3] = 16'h4000;
	w[4] = {ttl, 8'd17};
	w[5] = sip[31:16];
	w[6] = sip[15:0];
	w[7] = dip[31:16];
	w[8] = dip[15:0];
	s = 16'h0000;
	for (int i = 0; i < 9; i++)
	begin
		t = s + w[i];
		s = t[15:0] + t[16];
	end
	return ~s;
endfunction

// Ethernet CRC-32, one bit of the byte at a time, LSB first
function automatic logic [31:0] ref_crc_byte(input logic [31:0] c, input logic [7:0] b);
	logic fb;
	for (int i = 0; i < 8; i++)
	begin
		fb = c[0] ^ b[i];
		c  = c >> 1;
		if (fb)
			c = c ^ 32'hEDB8_8320;
	end
	return c;
endfunction

// Whole frame as it should appear on tx_data
function automatic void build_frame(input logic [255:0] p, input logic [47:0] dmac,
	input logic [47:0] smac, input logic [31:0] sip, input logic [31:0] dip,
	input logic [15:0] sport, input logic [15:0] dport, input logic [15:0] id,
	input logic [7:0] ttl, output logic [15:0] f [FRAME_LEN]);
	logic [31:0] crc;
	f[0]  = 16'h5555;
	f[1]  = 16'h5555;
	f[2]  = 16'h5555;
	f[3]  = 16'h55D5;
	f[4]  = dmac[47:32];
	f[5]  = dmac[31:16];
	f[6]  = dmac[15:0];
	f[7]  = smac[47:32];
	f[8]  = smac[31:16];
	f[9]  = smac[15:0];
	f[10] = 16'h0800;
	f[11] = 16'h4500;
	f[12] = 16'd60;
	f[13] = id;
	f[14] = 16'h4000;
	f[15] = {ttl, 8'd17};
	f[16] = ref_ip_checksum(sip, dip, id, ttl);
	f[17] = sip[31:16];
	f[18] = sip[15:0];
	f[19] = dip[31:16];
	f[20] = dip[15:0];
	f[21] = sport;
	f[22] = dport;
	f[23] = 16'd40;   // UDP length
	f[24] = 16'h0000;
	for (int i = 0; i < 16; i++)
		f[25 + i] = p[255 - 16*i -: 16];
	crc = 32'hFFFF_FFFF;
	for (int i = 4; i < 41; i++)   // From dst_mac to the payload end
	begin
		crc = ref_crc_byte(crc, f[i][15:8]);
		crc = ref_crc_byte(crc, f[i][7:0]);
	end
	crc   = ~crc;
	f[41] = {crc[7:0], crc[15:8]};
	f[42] = {crc[23:16], crc[31:24]};
endfunction

`endif

//--- tests/udp_tx_tb.sv
`timescale 1ns/100ps
`include "udp_tx_macros.svh"

module udp_tx_tb;

	localparam int ROWS       = 5;
	localparam int RST_CYCLES = 8;
	localparam int FRAME_LEN  = 43;

	logic                     clk;
	logic                     rst_n;
	logic                     cfg_wr;
	logic [3:0]               cfg_addr;
	logic [31:0]              cfg_wdata;
	logic [`PAYLOAD_BITS-1:0] send_package;
	logic                     send_valid;
	logic                     drop;
	logic [`WORD_W-1:0]       tx_data;
	logic                     tx_valid, tx_sof, tx_eof;

	// Stimulus table
	logic        row_wr    [ROWS];
	logic [31:0] row_regs  [ROWS][8];
	logic [31:0] row_seed  [ROWS];
	int          row_burst [ROWS];
	int          row_drops [ROWS];   // Refused payloads expected

	// Header fields as software last wrote them
	logic [47:0] m_dst_mac, m_src_mac;
	logic [31:0] m_src_ip, m_dst_ip;
	logic [15:0] m_src_port, m_dst_port, m_ip_id;
	logic [7:0]  m_ttl;

	logic [15:0] exp_words [$];
	integer      seed;
	int          cycle = 0;
	int          word_idx = 0;
	int          idle_run = 0;
	int          drop_seen = 0;
	int          first_due = -1;

	`include "udp_tx_ref.svh"

	udp_tx_top dut
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.cfg_wr       (cfg_wr),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.send_package (send_package),
		.send_valid   (send_valid),
		.drop         (drop),
		.tx_data      (tx_data),
		.tx_valid     (tx_valid),
		.tx_sof       (tx_sof),
		.tx_eof       (tx_eof)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	//////////////////////////////////////////////////
	// Checking helpers
	task automatic stop_with_failure();
		$display("Test failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (exp !== got)
		begin
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
			stop_with_failure();
		end
	endtask

	task automatic set_row(input int r, input logic wr, input logic [31:0] s, input int burst,
		input int drops, input logic [255:0] regs);
		row_wr[r]    = wr;
		row_seed[r]  = s;
		row_burst[r] = burst;
		row_drops[r] = drops;
		for (int i = 0; i < 8; i++)
			row_regs[r][i] = regs[255 - 32*i -: 32];
	endtask

	// Register values in address order 0 to 7
	task automatic load_table();
		set_row(0, 1'b0, 32'h0, 1, 0, '0);   // Reset header values
		set_row(1, 1'b1, 32'h11, 1, 0, {32'h0000_0A1B, 32'h2C3D_4E5F, 32'h0000_0200,
			32'h1122_3344, 32'hC0A8_0001, 32'hC0A8_0064, 32'h1F90_0035, 32'h1234_0080});
		set_row(2, 1'b0, 32'h22, 3, 0, '0);
		// One payload in the framer, four queued, the sixth refused
		set_row(3, 1'b1, 32'h33, 6, 1, {32'h0000_FFFF, 32'hFFFF_FFFF, 32'h0000_0002,
			32'h0000_0003, 32'h0A00_0001, 32'h0A00_00FE, 32'hC000_0050, 32'hBEEF_0020});
		set_row(4, 1'b1, 32'h44, 2, 0, {32'h0000_0100, 32'h5E00_00FB, 32'h0000_00AA,
			32'hBBCC_DDEE, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_A5FF});
	endtask

	//////////////////////////////////////////////////
	// Drivers
	task automatic write_reg(input int a, input logic [31:0] d);
		@(posedge clk);
		#2;
		cfg_wr    = 1'b1;
		cfg_addr  = a[3:0];
		cfg_wdata = d;
		case (a)
			0: m_dst_mac[47:32] = d[15:0];
			1: m_dst_mac[31:0]  = d;
			2: m_src_mac[47:32] = d[15:0];
			3: m_src_mac[31:0]  = d;
			4: m_src_ip         = d;
			5: m_dst_ip         = d;
			6:
			begin
				m_src_port = d[31:16];
				m_dst_port = d[15:0];
			end
			default:
			begin
				m_ip_id = d[31:16];
				m_ttl   = d[7:0];
			end
		endcase
	endtask

	task automatic send_burst(input int n, input int drops);
		logic [`PAYLOAD_BITS-1:0] p;
		logic [15:0]              f [FRAME_LEN];
		for (int i = 0; i < n; i++)
		begin
			for (int k = 0; k < 8; k++)
				p[32*k +: 32] = $random(seed);
			@(posedge clk);
			#2;
			if (i == 0)
				first_due = cycle + 3;   // Sampling edge plus two, seen at the falling edge
			send_valid   = 1'b1;
			send_package = p;
			if (i < n - drops)   // Trailing payloads meet a full queue
			begin
				build_frame(p, m_dst_mac, m_src_mac, m_src_ip, m_dst_ip, m_src_port,
					m_dst_port, m_ip_id, m_ttl, f);
				for (int w = 0; w < FRAME_LEN; w++)
					exp_words.push_back(f[w]);
			end
		end
		@(posedge clk);
		#2;
		send_valid = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Frame capture, sampled away from the rising edge
	always @(negedge clk)
	begin
		logic [15:0] exp_w;
		if (rst_n)
		begin
			if (drop)
				drop_seen++;
			if (tx_valid)
			begin
				if (word_idx == 0)
				begin
					if (first_due >= 0)
					begin
						check_value("tx_valid latency cycle", first_due, cycle);
						first_due = -1;
					end
					else
						check_value("idle cycles before queued frame", `GAP_CYCLES + 1,
							idle_run);   // Gap, then the pop cycle
				end
				check_value("tx_sof", word_idx == 0, tx_sof);
				check_value("tx_eof", word_idx == FRAME_LEN - 1, tx_eof);
				if (exp_words.size() == 0)
				begin
					$display("A frame word appeared on tx_data with no frame pending");
					stop_with_failure();
				end
				else
				begin
					exp_w = exp_words.pop_front();
					check_value("tx_data", exp_w, tx_data);
				end
				idle_run = 0;
				word_idx = (word_idx == FRAME_LEN - 1) ? 0 : word_idx + 1;
			end
			else if (word_idx != 0)
			begin
				$display("tx_valid went low in the middle of a frame");
				stop_with_failure();
			end
			else
			begin
				check_value("tx_sof", 1'b0, tx_sof);
				check_value("tx_eof", 1'b0, tx_eof);
				idle_run++;
			end
		end
	end

	// Watchdog sized from the table
	initial
	begin
		int limit;
		#1;
		limit = RST_CYCLES + 100;
		for (int r = 0; r < ROWS; r++)
			limit = limit + row_burst[r] * 60 + 30;
		repeat (limit) @(posedge clk);
		$display("Watchdog expired, the frames never completed");
		stop_with_failure();
	end

	//////////////////////////////////////////////////
	// Main sequence
	initial
	begin
		int base;
		rst_n        = 1'b0;
		cfg_wr       = 1'b0;
		cfg_addr     = '0;
		cfg_wdata    = '0;
		send_package = '0;
		send_valid   = 1'b0;
		seed         = 32'h2f59;
		m_dst_mac    = `RESET_DST_MAC;
		m_src_mac    = `RESET_SRC_MAC;
		m_dst_ip     = `RESET_DST_IP;
		m_src_ip     = `RESET_SRC_IP;
		m_dst_port   = `RESET_DST_PORT;
		m_src_port   = `RESET_SRC_PORT;
		m_ip_id      = 16'h0000;
		m_ttl        = `RESET_TTL;
		load_table();

		repeat (RST_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		check_value("tx_valid", 1'b0, tx_valid);
		check_value("tx_sof", 1'b0, tx_sof);
		check_value("tx_eof", 1'b0, tx_eof);
		check_value("drop", 1'b0, drop);
		check_value("tx_data", 16'h0000, tx_data);

		for (int r = 0; r < ROWS; r++)
		begin
			if (row_wr[r])
			begin
				for (int a = 0; a < 8; a++)
					write_reg(a, row_regs[r][a]);
				@(posedge clk);
				#2;
				cfg_wr = 1'b0;
			end
			seed = 32'h2f59 + row_seed[r];
			base = drop_seen;
			send_burst(row_burst[r], row_drops[r]);
			while (exp_words.size() != 0 || word_idx != 0)
				@(posedge clk);
			repeat (12) @(posedge clk);   // Gap, then back to idle
			check_value("drop pulse count", row_drops[r], drop_seen - base);
		end

		$display("Test passed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+hdl
+incdir+tests
hdl/udp_tx_pkg.sv
hdl/hdr_cfg_if.sv
hdl/udp_cfg_regs.sv
hdl/payload_queue.sv
hdl/crc32_eth.sv
hdl/udp_frame_tx.sv
hdl/udp_tx_top.sv
tests/udp_tx_tb.sv
